//--- Bender.yml
package:
  name: seeg_acq

sources:
  - common/seeg_pkg.sv
  - engine/array_engine.sv
  - sequencer/acq_sequencer.sv
  - src/result_stage.sv
  - src/seeg_top.sv
  - target: test
    files:
      - dv/tb_seeg.sv

//--- common/seeg_pkg.sv
package seeg_pkg;

    // array sizes at simulation scale
    localparam int RHD_CHANNELS = 8;
    localparam int RHS_CHANNELS = 4;
    localparam int ZCHECK_SAMPLES = 8; // samples captured per impedance block

    // engine ticks per configuration pass
    localparam int CONFIG_WORDS = 10;

    localparam int RHD_CLOCK_DIV = 2; // recording array ticks at half rate
    localparam int RHS_CLOCK_DIV = 1;

    // base values of the built-in data generators
    localparam int RHD_SEED = 0;
    localparam int RHS_SEED = 128;

    typedef logic [15:0] sample_t;

    typedef logic [3:0] chan_t; // array-local and global channel index

    typedef logic [1:0] zscale_t; // test-current scale, applied as a left shift

    // channel 0 sits in the low word
    typedef sample_t [RHD_CHANNELS-1:0] rhd_frame_t;
    typedef sample_t [RHS_CHANNELS-1:0] rhs_frame_t;

    typedef struct packed {
        rhs_frame_t rhs;
        rhd_frame_t rhd;
    } record_frame_t;

    typedef sample_t [ZCHECK_SAMPLES-1:0] zcheck_block_t;

    typedef enum logic [1:0] {
        op_config,
        op_record,
        op_zcheck
    } engine_op_e;

endpackage

//--- dv/tb_seeg.sv
`timescale 1ns/1ps

module tb_seeg;

    localparam int FRAMES_PER_SESSION = 6;
    localparam int RECORD_SESSIONS = 3;
    localparam int SWEEPS = 5;
    localparam int BLOCKS = seeg_pkg::RHD_CHANNELS + seeg_pkg::RHS_CHANNELS;
    localparam int CYCLES_PER_ITEM = 80; // worst case for one scan or block under back-pressure
    localparam int LIMIT_CYCLES =
        (RECORD_SESSIONS * (FRAMES_PER_SESSION + 4) + SWEEPS * BLOCKS) * CYCLES_PER_ITEM + 500;

    logic clk;
    logic config_done_reset_flag;
    logic record_start, record_stop, zcheck_start;
    seeg_pkg::zscale_t zcheck_scale;
    logic record_ready, zcheck_ready;
    logic busy, zcheck_done, record_valid, zcheck_valid;
    seeg_pkg::record_frame_t record_frame;
    seeg_pkg::zcheck_block_t zcheck_block;
    seeg_pkg::chan_t zcheck_channel;

    int errors = 0;
    int rec_idx = 0;
    int z_idx = 0;
    int done_count = 0;
    bit rec_random = 1'b0;
    bit z_random = 1'b0;
    seeg_pkg::zscale_t sweep_scale = '0;
    bit rec_held = 1'b0;
    bit z_held = 1'b0;
    seeg_pkg::record_frame_t held_frame;
    seeg_pkg::zcheck_block_t held_block;

    seeg_top uut (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start), .record_stop(record_stop), .zcheck_start(zcheck_start),
        .zcheck_scale(zcheck_scale), .record_ready(record_ready), .zcheck_ready(zcheck_ready),
        .busy(busy), .zcheck_done(zcheck_done), .record_frame(record_frame),
        .record_valid(record_valid), .zcheck_block(zcheck_block),
        .zcheck_channel(zcheck_channel), .zcheck_valid(zcheck_valid)
    );

    // sample c of scan n is seed + 64n + c on both arrays
    function automatic seeg_pkg::record_frame_t exp_frame(input int n);
        seeg_pkg::record_frame_t f;
        for (int c = 0; c < seeg_pkg::RHD_CHANNELS; c++)
            f.rhd[c] = 16'((seeg_pkg::RHD_SEED + 64 * n + c) & 16'hffff);
        for (int c = 0; c < seeg_pkg::RHS_CHANNELS; c++)
            f.rhs[c] = 16'((seeg_pkg::RHS_SEED + 64 * n + c) & 16'hffff);
        return f;
    endfunction

    function automatic seeg_pkg::zcheck_block_t exp_zblock(input int g, input int scale);
        seeg_pkg::zcheck_block_t b;
        int seed;
        int c;
        seed = (g < seeg_pkg::RHD_CHANNELS) ? seeg_pkg::RHD_SEED : seeg_pkg::RHS_SEED;
        c = (g < seeg_pkg::RHD_CHANNELS) ? g : g - seeg_pkg::RHD_CHANNELS; // local channel
        for (int k = 0; k < seeg_pkg::ZCHECK_SAMPLES; k++)
            b[k] = 16'(((seed + 8 * c + k) << scale) & 16'hffff);
        return b;
    endfunction

    task automatic check_value(input logic [191:0] actual, input logic [191:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        record_ready = rec_random ? 1'($urandom % 2) : 1'b1;
        zcheck_ready = z_random ? 1'($urandom % 2) : 1'b1;
    end

    // each item is checked on the edge where the outside ready takes it
    always @(posedge clk) begin
        if (!config_done_reset_flag) begin
            if (rec_held) begin
                check_value(record_valid, 1'b1, "record_valid while held");
                check_value(record_frame, held_frame, "held record_frame");
            end
            if (z_held) begin
                check_value(zcheck_valid, 1'b1, "zcheck_valid while held");
                check_value(zcheck_block, held_block, "held zcheck_block");
            end
            if (record_valid && record_ready) begin
                check_value(record_frame, exp_frame(rec_idx), $sformatf("frame %0d", rec_idx));
                rec_idx++;
            end
            if (zcheck_valid && zcheck_ready) begin
                check_value(zcheck_channel, z_idx[3:0], "zcheck_channel");
                check_value(zcheck_block, exp_zblock(z_idx, sweep_scale),
                            $sformatf("block %0d", z_idx));
                z_idx++;
            end
            if (zcheck_done) begin
                done_count++;
                check_value(busy, 1'b0, "busy on zcheck_done");
                check_value(z_idx + int'(zcheck_valid && !zcheck_ready), BLOCKS,
                            "blocks before zcheck_done");
            end
            rec_held = record_valid && !record_ready;
            held_frame = record_frame;
            z_held = zcheck_valid && !zcheck_ready;
            held_block = zcheck_block;
        end
    end

    task automatic record_session(input bit random_ready);
        rec_random = random_ready;
        rec_idx = 0;
        drive_edge();
        record_start = 1'b1;
        drive_edge();
        record_start = 1'b0;
        wait (rec_idx >= FRAMES_PER_SESSION);
        drive_edge();
        record_stop = 1'b1;
        drive_edge();
        record_stop = 1'b0;
        wait (!busy);
        wait (!record_valid);
        rec_random = 1'b0;
        repeat (3) drive_edge();
    endtask

    task automatic impedance_sweep(input seeg_pkg::zscale_t scale, input bit random_ready);
        z_random = random_ready;
        z_idx = 0;
        done_count = 0;
        sweep_scale = scale;
        drive_edge();
        zcheck_scale = scale;
        zcheck_start = 1'b1;
        drive_edge();
        zcheck_start = 1'b0;
        wait (done_count > 0 && !busy && !zcheck_valid);
        repeat (5) drive_edge(); // room for a stray second done pulse
        check_value(done_count, 1, "zcheck_done pulse count");
        check_value(z_idx, BLOCKS, "block count");
        z_random = 1'b0;
    endtask

    initial begin
        void'($urandom(72));
        config_done_reset_flag = 1'b1;
        record_start = 1'b0;
        record_stop = 1'b0;
        zcheck_start = 1'b0;
        zcheck_scale = '0;
        record_ready = 1'b1;
        zcheck_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        config_done_reset_flag = 1'b0;
        check_value(busy, 1'b0, "busy after reset");
        check_value(record_valid, 1'b0, "record_valid after reset");
        check_value(zcheck_valid, 1'b0, "zcheck_valid after reset");
        check_value(zcheck_done, 1'b0, "zcheck_done after reset");
        record_session(1'b0);
        record_session(1'b1);
        record_session(1'b0); // restarts at scan 0 after the stop
        impedance_sweep(2'd0, 1'b0);
        for (int s = 0; s < 4; s++)
            impedance_sweep(seeg_pkg::zscale_t'(s), 1'b1);
        $display("Error count: %0d", errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * 4);
        $display("Timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
        $display("Error count: %0d", errors);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- engine/array_engine.sv
`timescale 1ns/1ps

module array_engine #(
    parameter int CHANNELS = 8,
    parameter int SEED = 0,
    parameter int CLOCK_DIV = 1,
    parameter type frame_t = logic [CHANNELS*16-1:0]
) (
    input  logic                      clk,
    input  logic                      config_done_reset_flag,
    input  logic                      start_valid,
    input  seeg_pkg::engine_op_e      start_op,
    input  seeg_pkg::chan_t           start_channel,
    input  seeg_pkg::zscale_t         zcheck_scale,
    output logic                      start_ready,
    output logic                      done,
    output frame_t                    frame,
    output seeg_pkg::zcheck_block_t   zblock
);

    logic busy;
    logic accept;
    logic tick;
    logic [3:0] div_cnt;
    logic [7:0] pos;
    logic [7:0] last_pos;
    seeg_pkg::engine_op_e op_q;
    seeg_pkg::sample_t frame_idx;
    seeg_pkg::chan_t chan_q;
    seeg_pkg::zscale_t scale_q;
    seeg_pkg::sample_t rec_sample;
    seeg_pkg::sample_t z_base;
    logic [$bits(frame_t)-1:0] frame_r;
    logic [$bits(seeg_pkg::zcheck_block_t)-1:0] zblock_r;

    assign start_ready = !busy;
    assign accept = start_valid && !busy;
    assign tick = div_cnt == 4'(CLOCK_DIV - 1); // clock enable for this array

    // generator, 64 per frame plus channel, or 8 per channel plus sample
    assign rec_sample = seeg_pkg::sample_t'(SEED) + {frame_idx[9:0], 6'b0}
                      + seeg_pkg::sample_t'(pos);
    assign z_base = seeg_pkg::sample_t'(SEED) + {9'b0, chan_q, 3'b0} + seeg_pkg::sample_t'(pos);

    assign frame = frame_t'(frame_r);
    assign zblock = seeg_pkg::zcheck_block_t'(zblock_r);

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            busy <= 1'b0;
            done <= 1'b0;
            div_cnt <= '0;
            pos <= '0;
            last_pos <= '0;
            op_q <= seeg_pkg::op_config;
            frame_idx <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                div_cnt <= '0;
                pos <= '0;
                op_q <= start_op;
                case (start_op)
                    seeg_pkg::op_record: last_pos <= 8'(CHANNELS - 1);
                    seeg_pkg::op_zcheck: last_pos <= 8'(seeg_pkg::ZCHECK_SAMPLES - 1);
                    default:             last_pos <= 8'(seeg_pkg::CONFIG_WORDS - 1);
                endcase
                if (start_op == seeg_pkg::op_config) frame_idx <= '0; // scan count restarts
            end else if (done) begin
                busy <= 1'b0; // ready again the cycle after done
            end else if (busy) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    pos <= pos + 1'b1;
                    if (pos == last_pos) begin
                        done <= 1'b1;
                        if (op_q == seeg_pkg::op_record) frame_idx <= frame_idx + 1'b1;
                    end
                end
            end
        end
    end

    // samples shift in from the top so the first one ends in the low word
    always_ff @(posedge clk) begin
        if (accept) begin
            chan_q <= start_channel;
            scale_q <= zcheck_scale;
        end
        if (busy && !done && tick) begin
            if (op_q == seeg_pkg::op_record)
                frame_r <= {rec_sample, frame_r[$bits(frame_t)-1:16]};
            if (op_q == seeg_pkg::op_zcheck)
                zblock_r <= {z_base << scale_q, zblock_r[$bits(zblock_r)-1:16]};
        end
    end

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        done |-> !start_ready ##1 start_ready);

    // the sweep counter in the sequencer must stay inside this array
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        accept && start_op == seeg_pkg::op_zcheck |-> start_channel < CHANNELS);

endmodule

//--- sequencer/acq_sequencer.sv
`timescale 1ns/1ps

module acq_sequencer (
    input  logic                      clk,
    input  logic                      config_done_reset_flag,
    input  logic                      record_start,
    input  logic                      record_stop,
    input  logic                      zcheck_start,
    input  logic                      rhd_start_ready,
    input  logic                      rhs_start_ready,
    input  logic                      rhd_done,
    input  logic                      rhs_done,
    input  seeg_pkg::rhd_frame_t      rhd_frame,
    input  seeg_pkg::rhs_frame_t      rhs_frame,
    input  seeg_pkg::zcheck_block_t   rhd_zblock,
    input  seeg_pkg::zcheck_block_t   rhs_zblock,
    input  logic                      rec_ready,
    input  logic                      z_ready,
    output logic                      busy,
    output logic                      zcheck_done,
    output logic                      rhd_start_valid,
    output logic                      rhs_start_valid,
    output seeg_pkg::engine_op_e      start_op,
    output seeg_pkg::chan_t           start_channel,
    output logic                      rec_push,
    output seeg_pkg::record_frame_t   rec_data,
    output logic                      z_push,
    output seeg_pkg::zcheck_block_t   z_data,
    output seeg_pkg::chan_t           z_channel
);

    typedef enum logic [3:0] {
        s_ready, s_cfg_issue, s_cfg_wait, s_rec_issue, s_rec_wait, s_rec_push,
        s_z_issue, s_z_wait, s_z_push, s_reconfig
    } state_t;

    state_t state;
    logic rhd_acc, rhs_acc, rhd_got, rhs_got;
    logic reconfig_pending, stop_pending, zcheck_mode;
    seeg_pkg::chan_t sweep_ch;
    seeg_pkg::rhd_frame_t rhd_q;
    seeg_pkg::rhs_frame_t rhs_q;
    seeg_pkg::zcheck_block_t z_q;
    logic both_engines, z_phase, z_on_rhd, need_rhd, need_rhs, issuing, waiting;
    logic rhd_fire, rhs_fire, all_acc, all_got, sweep_last;

    assign both_engines = state inside {s_cfg_issue, s_cfg_wait, s_rec_issue, s_rec_wait};
    assign z_phase = state inside {s_z_issue, s_z_wait};
    assign z_on_rhd = sweep_ch < seeg_pkg::chan_t'(seeg_pkg::RHD_CHANNELS); // rhd first in sweep
    assign need_rhd = both_engines || (z_phase && z_on_rhd);
    assign need_rhs = both_engines || (z_phase && !z_on_rhd);
    assign issuing = state inside {s_cfg_issue, s_rec_issue, s_z_issue};
    assign waiting = state inside {s_cfg_wait, s_rec_wait, s_z_wait};
    assign sweep_last = sweep_ch ==
        seeg_pkg::chan_t'(seeg_pkg::RHD_CHANNELS + seeg_pkg::RHS_CHANNELS - 1);

    assign rhd_start_valid = issuing && need_rhd && !rhd_acc;
    assign rhs_start_valid = issuing && need_rhs && !rhs_acc;
    assign rhd_fire = rhd_start_valid && rhd_start_ready;
    assign rhs_fire = rhs_start_valid && rhs_start_ready;
    assign all_acc = (!need_rhd || rhd_acc || rhd_fire) && (!need_rhs || rhs_acc || rhs_fire);
    assign all_got = (!need_rhd || rhd_got) && (!need_rhs || rhs_got);

    always_comb begin
        case (state)
            s_rec_issue: start_op = seeg_pkg::op_record;
            s_z_issue:   start_op = seeg_pkg::op_zcheck;
            default:     start_op = seeg_pkg::op_config;
        endcase
    end

    assign start_channel = z_on_rhd ? sweep_ch
                                    : sweep_ch - seeg_pkg::chan_t'(seeg_pkg::RHD_CHANNELS);
    assign busy = state != s_ready;
    assign rec_push = state == s_rec_push;
    assign rec_data = {rhs_q, rhd_q};
    assign z_push = state == s_z_push;
    assign z_data = z_q;
    assign z_channel = sweep_ch; // global index, rhs channels follow rhd

    // engine results land here whatever the op, only the relevant one is pushed
    always_ff @(posedge clk) begin
        if (rhd_done) rhd_q <= rhd_frame;
        if (rhs_done) rhs_q <= rhs_frame;
        if (rhd_done) z_q <= rhd_zblock;
        else if (rhs_done) z_q <= rhs_zblock;
    end

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            state <= s_ready;
            {rhd_acc, rhs_acc, rhd_got, rhs_got} <= '0;
            {reconfig_pending, stop_pending, zcheck_mode} <= '0;
            sweep_ch <= '0;
            zcheck_done <= 1'b0;
        end else begin
            zcheck_done <= 1'b0;
            if (record_stop && busy) stop_pending <= 1'b1;
            if (rhd_fire) rhd_acc <= 1'b1;
            if (rhs_fire) rhs_acc <= 1'b1;
            if (issuing && all_acc) {rhd_acc, rhs_acc} <= '0;
            if (rhd_done) rhd_got <= 1'b1;
            if (rhs_done) rhs_got <= 1'b1;
            if (waiting && all_got) {rhd_got, rhs_got} <= '0;

            case (state)
                s_ready: begin
                    if (record_start || zcheck_start) begin
                        zcheck_mode <= !record_start; // record wins if both are high
                        stop_pending <= 1'b0;
                        state <= s_cfg_issue;
                    end
                end
                s_cfg_issue: if (all_acc) state <= s_cfg_wait;
                s_cfg_wait: begin
                    if (all_got) begin
                        if (reconfig_pending) begin
                            reconfig_pending <= 1'b0;
                            zcheck_done <= zcheck_mode;
                            state <= s_ready;
                        end else if (zcheck_mode) begin
                            sweep_ch <= '0;
                            state <= s_z_issue;
                        end else begin
                            state <= s_rec_issue;
                        end
                    end
                end
                s_rec_issue: if (all_acc) state <= s_rec_wait;
                s_rec_wait:  if (all_got) state <= s_rec_push;
                s_rec_push:  if (rec_ready) state <= stop_pending ? s_reconfig : s_rec_issue;
                s_z_issue:   if (all_acc) state <= s_z_wait;
                s_z_wait:    if (all_got) state <= s_z_push;
                s_z_push: begin
                    if (z_ready) begin
                        sweep_ch <= sweep_last ? sweep_ch : sweep_ch + 1'b1;
                        state <= sweep_last ? s_reconfig : s_z_issue;
                    end
                end
                s_reconfig: begin
                    reconfig_pending <= 1'b1;
                    if (rhd_start_ready && rhs_start_ready) state <= s_cfg_issue;
                end
                default: state <= s_ready;
            endcase
        end
    end

    // a presented item stays until the result stage takes it
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        rec_push && !rec_ready |=> rec_push && $stable(rec_data));
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        z_push && !z_ready |=> z_push && $stable(z_data) && $stable(z_channel));

endmodule

//--- src.f
common/seeg_pkg.sv
engine/array_engine.sv
sequencer/acq_sequencer.sv
src/result_stage.sv
src/seeg_top.sv
dv/tb_seeg.sv

//--- src/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                      clk,
    input  logic                      config_done_reset_flag,
    input  logic                      rec_push,
    input  seeg_pkg::record_frame_t   rec_data,
    input  logic                      z_push,
    input  seeg_pkg::zcheck_block_t   z_data,
    input  seeg_pkg::chan_t           z_channel,
    input  logic                      record_ready,
    input  logic                      zcheck_ready,
    output logic                      rec_ready,
    output logic                      z_ready,
    output seeg_pkg::record_frame_t   record_frame,
    output logic                      record_valid,
    output seeg_pkg::zcheck_block_t   zcheck_block,
    output seeg_pkg::chan_t           zcheck_channel,
    output logic                      zcheck_valid
);

    // a slot takes a new item when empty or when it drains on this edge
    assign rec_ready = !record_valid || record_ready;
    assign z_ready = !zcheck_valid || zcheck_ready;

    always_ff @(posedge clk) begin
        if (config_done_reset_flag) begin
            record_valid <= 1'b0;
            zcheck_valid <= 1'b0;
        end else begin
            if (rec_push && rec_ready) record_valid <= 1'b1;
            else if (record_ready) record_valid <= 1'b0;
            if (z_push && z_ready) zcheck_valid <= 1'b1;
            else if (zcheck_ready) zcheck_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rec_push && rec_ready) record_frame <= rec_data;
        if (z_push && z_ready) begin
            zcheck_block <= z_data;
            zcheck_channel <= z_channel;
        end
    end

    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        record_valid && !record_ready |=> record_valid && $stable(record_frame));
    assert property (@(posedge clk) disable iff (config_done_reset_flag)
        zcheck_valid && !zcheck_ready |=>
            zcheck_valid && $stable(zcheck_block) && $stable(zcheck_channel));

endmodule

//--- src/seeg_top.sv
`timescale 1ns/1ps

module seeg_top (
    input  logic                      clk,
    input  logic                      config_done_reset_flag,
    input  logic                      record_start,
    input  logic                      record_stop,
    input  logic                      zcheck_start,
    input  seeg_pkg::zscale_t         zcheck_scale,
    input  logic                      record_ready,
    input  logic                      zcheck_ready,
    output logic                      busy,
    output logic                      zcheck_done,
    output seeg_pkg::record_frame_t   record_frame,
    output logic                      record_valid,
    output seeg_pkg::zcheck_block_t   zcheck_block,
    output seeg_pkg::chan_t           zcheck_channel,
    output logic                      zcheck_valid
);

    logic rhd_start_valid;
    logic rhs_start_valid;
    logic rhd_start_ready;
    logic rhs_start_ready;
    logic rhd_done;
    logic rhs_done;
    seeg_pkg::engine_op_e start_op;
    seeg_pkg::chan_t start_channel;
    seeg_pkg::rhd_frame_t rhd_frame;
    seeg_pkg::rhs_frame_t rhs_frame;
    seeg_pkg::zcheck_block_t rhd_zblock;
    seeg_pkg::zcheck_block_t rhs_zblock;
    logic rec_push;
    logic rec_ready;
    seeg_pkg::record_frame_t rec_data;
    logic z_push;
    logic z_ready;
    seeg_pkg::zcheck_block_t z_data;
    seeg_pkg::chan_t z_channel;

    acq_sequencer sequencer (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .record_start(record_start), .record_stop(record_stop), .zcheck_start(zcheck_start),
        .rhd_start_ready(rhd_start_ready), .rhs_start_ready(rhs_start_ready),
        .rhd_done(rhd_done), .rhs_done(rhs_done),
        .rhd_frame(rhd_frame), .rhs_frame(rhs_frame),
        .rhd_zblock(rhd_zblock), .rhs_zblock(rhs_zblock),
        .rec_ready(rec_ready), .z_ready(z_ready),
        .busy(busy), .zcheck_done(zcheck_done),
        .rhd_start_valid(rhd_start_valid), .rhs_start_valid(rhs_start_valid),
        .start_op(start_op), .start_channel(start_channel),
        .rec_push(rec_push), .rec_data(rec_data),
        .z_push(z_push), .z_data(z_data), .z_channel(z_channel)
    );

    // recording array, ticks on every second clock
    array_engine #(
        .CHANNELS(seeg_pkg::RHD_CHANNELS), .SEED(seeg_pkg::RHD_SEED),
        .CLOCK_DIV(seeg_pkg::RHD_CLOCK_DIV), .frame_t(seeg_pkg::rhd_frame_t)
    ) rhd_engine (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .start_valid(rhd_start_valid), .start_op(start_op), .start_channel(start_channel),
        .zcheck_scale(zcheck_scale), .start_ready(rhd_start_ready), .done(rhd_done),
        .frame(rhd_frame), .zblock(rhd_zblock)
    );

    array_engine #(
        .CHANNELS(seeg_pkg::RHS_CHANNELS), .SEED(seeg_pkg::RHS_SEED),
        .CLOCK_DIV(seeg_pkg::RHS_CLOCK_DIV), .frame_t(seeg_pkg::rhs_frame_t)
    ) rhs_engine (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .start_valid(rhs_start_valid), .start_op(start_op), .start_channel(start_channel),
        .zcheck_scale(zcheck_scale), .start_ready(rhs_start_ready), .done(rhs_done),
        .frame(rhs_frame), .zblock(rhs_zblock)
    );

    result_stage results (
        .clk(clk), .config_done_reset_flag(config_done_reset_flag),
        .rec_push(rec_push), .rec_data(rec_data),
        .z_push(z_push), .z_data(z_data), .z_channel(z_channel),
        .record_ready(record_ready), .zcheck_ready(zcheck_ready),
        .rec_ready(rec_ready), .z_ready(z_ready),
        .record_frame(record_frame), .record_valid(record_valid),
        .zcheck_block(zcheck_block), .zcheck_channel(zcheck_channel),
        .zcheck_valid(zcheck_valid)
    );

endmodule
